//--- uart_link.f
hdl/uart_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_link.sv
verification/uart_link_sva.sv
verification/uart_link_checker.sv
verification/uart_link_tb.sv

//--- Makefile
# Verilator build and run of the serial link testbench.
# Any variable below can be overridden on the command line, e.g. make test LOG=run.log

SIM      ?= verilator
TOP      ?= uart_link_tb
FILELIST ?= uart_link.f
BUILD    ?= obj_dir
LOG      ?= sim.log
VFLAGS   ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(SIM), run $(TOP), judge the result from $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "Variables: SIM TOP FILELIST BUILD LOG VFLAGS"

test:
	$(SIM) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "No errors" $(LOG); then \
	  echo "Simulation passed."; \
	else \
	  echo "Simulation failed, see $(LOG)."; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- verification/uart_link_tb.sv
/*
  Testbench top of the serial link.
  Clock, reset, LFSR bytes, loopback or direct line drive, and the reference model.
  Runs six tests through the checker and prints the result of the run.
*/
`timescale 1ns/1ps

module uart_link_tb;

  localparam int clk_period   = 40;                                    // Clock period in ns.
  localparam int drive_dly    = 2;                                     // Inputs change after edges.
  localparam int bit_cycles   = int'(uart_pkg::baud_div);
  localparam int frame_cycles = bit_cycles * int'(uart_pkg::frame_bits);
  localparam int wait_limit   = frame_cycles + 2 * bit_cycles;         // Longest wait for a flag.

  logic                        clk;
  logic                        rst_n;
  logic                        trmt;
  logic [uart_pkg::data_w-1:0] tx_data;
  logic                        tx_done;
  logic                        tx_line;
  logic                        rx_line;
  logic                        clr_rdy;
  logic [uart_pkg::data_w-1:0] rx_data;
  logic                        rdy;
  logic                        frame_err;
  logic                        direct_mode;   // Receiver takes drv_line instead of tx_line.
  logic                        drv_line;      // Line level driven by the testbench.
  logic [2:0]                  test_num;
  logic                        reset_stb;
  logic                        line_stb;
  logic                        exp_line;
  logic                        rx_chk_en;
  logic [uart_pkg::data_w-1:0] exp_data;
  logic                        exp_err;
  logic                        timeout_stb;
  logic                        test_end;
  logic                        report_stb;
  int                          err_cnt;
  logic [31:0]                 lfsr;          // Random byte source.

  assign rx_line = direct_mode ? drv_line : tx_line;   // Loopback unless driven directly.

  bind uart_tx uart_link_sva i_tx_sva (.clk(clk), .rst_n(rst_n), .tx_busy(state),
    .tx_line(tx_line), .tx_done(tx_done), .rdy(1'b0), .stop_sample(1'b0));
  bind uart_rx uart_link_sva i_rx_sva (.clk(clk), .rst_n(rst_n), .tx_busy(1'b0),
    .tx_line(1'b1), .tx_done(1'b0), .rdy(rdy), .stop_sample(stop_sample));

  uart_link i_uart_link (.clk(clk), .rst_n(rst_n), .trmt(trmt), .tx_data(tx_data),
    .tx_done(tx_done), .tx_line(tx_line), .rx_line(rx_line), .clr_rdy(clr_rdy),
    .rx_data(rx_data), .rdy(rdy), .frame_err(frame_err));

  uart_link_checker i_checker (.clk(clk), .rst_n(rst_n), .tx_done(tx_done), .tx_line(tx_line),
    .rx_data(rx_data), .rdy(rdy), .frame_err(frame_err), .clr_rdy(clr_rdy),
    .test_num(test_num), .reset_stb(reset_stb), .line_stb(line_stb), .exp_line(exp_line),
    .rx_chk_en(rx_chk_en), .exp_data(exp_data), .exp_err(exp_err),
    .timeout_stb(timeout_stb), .test_end(test_end), .report_stb(report_stb),
    .err_cnt(err_cnt));

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and random bytes.
  ////////////////////////////////////////////////////////////////////////////
  // Expected {frame_err, rx_data}: data as driven, error when the stop bit is 0.
  function automatic logic [uart_pkg::data_w:0] expected_rx(
      input logic [uart_pkg::data_w-1:0] data, input logic stop);
    return {~stop, data};
  endfunction

  // Line levels of one frame, index 0 first: start 0, data LSB first, then stop.
  function automatic logic [uart_pkg::frame_bits-1:0] frame_of(
      input logic [uart_pkg::data_w-1:0] data, input logic stop);
    return {stop, data, 1'b0};
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};         // Taps 32, 22, 2, 1.
  endfunction

  task next_byte(output logic [uart_pkg::data_w-1:0] b);
    for (int i = 0; i < uart_pkg::data_w; i++) begin
      lfsr = lfsr_step(lfsr);                               // One step per bit taken.
      b[i] = lfsr[0];
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and wait tasks.
  ////////////////////////////////////////////////////////////////////////////
  task next_cycle();
    @(posedge clk);
    #drive_dly;
  endtask

  task wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task report_timeout(input string what);
    $display("Test %0d timed out after %0d cycles waiting for %s.", test_num, wait_limit, what);
    timeout_stb = 1'b1;
    next_cycle();
    timeout_stb = 1'b0;
  endtask

  task wait_rdy();
    int n;
    n = 0;
    while (!rdy && n < wait_limit) begin
      next_cycle();
      n++;
    end
    if (!rdy) report_timeout("rdy");
  endtask

  task wait_tx_done();
    int n;
    n = 0;
    while (!tx_done && n < wait_limit) begin
      next_cycle();
      n++;
    end
    if (!tx_done) report_timeout("tx_done");
  endtask

  task send_byte(input logic [uart_pkg::data_w-1:0] b);
    tx_data = b;
    trmt    = 1'b1;                                         // One-cycle strobe.
    next_cycle();
    trmt    = 1'b0;
  endtask

  task expect_frame(input logic [uart_pkg::data_w-1:0] b, input logic stop);
    logic [uart_pkg::data_w:0] r;
    r         = expected_rx(b, stop);
    exp_data  = r[uart_pkg::data_w-1:0];
    exp_err   = r[uart_pkg::data_w];
    rx_chk_en = 1'b1;
  endtask

  // Holds the checker enable one more cycle so it sees the rise, then clears rdy.
  task take_byte();
    next_cycle();
    rx_chk_en = 1'b0;
    clr_rdy   = 1'b1;
    next_cycle();
    clr_rdy   = 1'b0;
  endtask

  task sample_frame(input logic [uart_pkg::data_w-1:0] b);
    logic [uart_pkg::frame_bits-1:0] f;
    f = frame_of(b, 1'b1);
    wait_cycles(bit_cycles / 2);                            // Middle of the start bit.
    for (int i = 0; i < int'(uart_pkg::frame_bits); i++) begin
      exp_line = f[i];
      line_stb = 1'b1;
      next_cycle();
      line_stb = 1'b0;
      wait_cycles(bit_cycles - 1);
    end
  endtask

  task drive_frame(input logic [uart_pkg::frame_bits-1:0] f);
    for (int i = 0; i < int'(uart_pkg::frame_bits); i++) begin
      drv_line = f[i];
      wait_cycles(bit_cycles);
    end
    drv_line = 1'b1;                                        // Back to idle.
  endtask

  task end_test();
    test_end = 1'b1;
    next_cycle();
    test_end = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence.
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    logic [uart_pkg::data_w-1:0] b;
    rst_n       = 1'b0;
    trmt        = 1'b0;
    tx_data     = '0;
    clr_rdy     = 1'b0;
    direct_mode = 1'b0;
    drv_line    = 1'b1;
    test_num    = 3'd0;
    reset_stb   = 1'b0;
    line_stb    = 1'b0;
    exp_line    = 1'b1;
    rx_chk_en   = 1'b0;
    exp_data    = '0;
    exp_err     = 1'b0;
    timeout_stb = 1'b0;
    test_end    = 1'b0;
    report_stb  = 1'b0;
    lfsr        = 32'ha5a0c3b9;
    repeat (5) @(posedge clk);
    #drive_dly;
    rst_n = 1'b1;

    test_num  = 3'd1;
    reset_stb = 1'b1;
    next_cycle();
    reset_stb = 1'b0;
    end_test();

    test_num = 3'd2;                                        // Bits seen on the line.
    next_byte(b);
    expect_frame(b, 1'b1);
    send_byte(b);
    sample_frame(b);
    wait_tx_done();
    wait_rdy();
    take_byte();
    end_test();

    test_num = 3'd3;
    repeat (16) begin
      next_byte(b);
      expect_frame(b, 1'b1);
      send_byte(b);
      wait_rdy();
      take_byte();
      wait_tx_done();
    end
    end_test();

    test_num = 3'd4;                                        // Second strobe lands mid-frame.
    next_byte(b);
    expect_frame(b, 1'b1);
    send_byte(b);
    wait_cycles(3 * bit_cycles);
    send_byte(~b);
    wait_rdy();
    take_byte();
    wait_tx_done();
    wait_cycles(frame_cycles);                              // Any extra frame would raise rdy.
    end_test();

    test_num    = 3'd5;
    direct_mode = 1'b1;
    next_byte(b);
    expect_frame(b, 1'b0);
    drive_frame(frame_of(b, 1'b0));
    wait_rdy();
    take_byte();
    end_test();

    test_num = 3'd6;                                        // Quarter-bit low pulse first.
    drv_line = 1'b0;
    wait_cycles(bit_cycles / 4);
    drv_line = 1'b1;
    wait_cycles(frame_cycles);
    next_byte(b);
    expect_frame(b, 1'b1);
    drive_frame(frame_of(b, 1'b1));
    wait_rdy();
    take_byte();
    end_test();

    report_stb = 1'b1;
    next_cycle();
    report_stb = 1'b0;
    next_cycle();
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- verification/uart_link_checker.sv
/*
  Checker of the serial link testbench.
  Compares DUT outputs with expected values on strobes from the testbench top.
  Prints one line per finished test and the closing counts.
*/
`timescale 1ns/1ps

module uart_link_checker (
  input  logic                        clk,          // Testbench clock.
  input  logic                        rst_n,        // No checks while reset is low.
  input  logic                        tx_done,      // DUT outputs under watch.
  input  logic                        tx_line,
  input  logic [uart_pkg::data_w-1:0] rx_data,
  input  logic                        rdy,
  input  logic                        frame_err,
  input  logic                        clr_rdy,      // Watched so that rdy can be seen to clear.
  input  logic [2:0]                  test_num,     // Test now running.
  input  logic                        reset_stb,    // Compare all outputs with reset values.
  input  logic                        line_stb,     // Compare tx_line with exp_line.
  input  logic                        exp_line,
  input  logic                        rx_chk_en,    // A received byte is expected.
  input  logic [uart_pkg::data_w-1:0] exp_data,
  input  logic                        exp_err,
  input  logic                        timeout_stb,  // A wait in the testbench ran out.
  input  logic                        test_end,     // Close the current test.
  input  logic                        report_stb,   // Print the counts of the run.
  output int                          err_cnt       // Errors over the whole run.
);

  int   errs      = 0;     // Errors in all tests.
  int   test_errs = 0;     // Errors in the current test.
  int   checks    = 0;
  int   tests     = 0;
  int   failed    = 0;
  logic rdy_q     = 1'b0;  // rdy one cycle back, for rise detection.
  logic clr_q     = 1'b0;  // clr_rdy one cycle back.

  assign err_cnt = errs;

  function automatic string test_name(input logic [2:0] num);
    case (num)
      3'd1:    return "reset_state";
      3'd2:    return "frame_format";
      3'd3:    return "loopback";
      3'd4:    return "trmt_during_frame";
      3'd5:    return "stop_bit_error";
      3'd6:    return "start_glitch";
      default: return "none";
    endcase
  endfunction

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %b, actual %b", test_name(test_num), what, exp, act);
      test_errs++;
      errs++;
    end
  endtask

  task automatic check_byte(input string what, input logic [uart_pkg::data_w-1:0] exp,
                            input logic [uart_pkg::data_w-1:0] act);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name(test_num), what, exp, act);
      test_errs++;
      errs++;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      if (reset_stb) begin
        check_bit("tx_line", 1'b1, tx_line);                // Idle line level.
        check_bit("tx_done", 1'b0, tx_done);
        check_bit("rdy", 1'b0, rdy);
        check_bit("frame_err", 1'b0, frame_err);
        check_byte("rx_data", '0, rx_data);
      end
      if (line_stb) begin
        check_bit("tx_line", exp_line, tx_line);            // Middle of a bit on the line.
      end
      if (rdy && !rdy_q) begin
        if (rx_chk_en) begin
          check_byte("rx_data", exp_data, rx_data);
          check_bit("frame_err", exp_err, frame_err);
        end else begin
          $display("Test %s: rdy rose although no frame was expected.", test_name(test_num));
          test_errs++;
          errs++;
        end
      end
      if (clr_q && rdy) begin
        $display("Test %s: rdy stayed high after clr_rdy.", test_name(test_num));
        test_errs++;
        errs++;
      end
      if (timeout_stb) begin
        test_errs++;                                        // A flag never came in time.
        errs++;
      end
      if (test_end) begin
        tests++;
        if (test_errs == 0) begin
          $display("Test %0d %s: passed", test_num, test_name(test_num));
        end else begin
          failed++;
          $display("Test %0d %s: failed, %0d errors", test_num, test_name(test_num), test_errs);
        end
        test_errs = 0;
      end
      if (report_stb) begin
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed, checks, errs);
      end
    end
    rdy_q <= rdy;
    clr_q <= clr_rdy;
  end

endmodule

//--- verification/uart_link_sva.sv
/*
  Concurrent assertions of the serial link.
  Bound once into uart_tx and once into uart_rx; the stage that lacks a signal ties it off.
*/
`timescale 1ns/1ps

module uart_link_sva (
  input logic clk,          // System clock of the bound stage.
  input logic rst_n,        // Assertions are off during reset.
  input logic tx_busy,      // Transmitter FSM is in its frame state.
  input logic tx_line,      // Transmitter serial output.
  input logic tx_done,      // Transmitter done flag.
  input logic rdy,          // Receiver ready flag.
  input logic stop_sample   // Receiver takes the stop bit this cycle.
);

  ////////////////////////////////////////////////////////////////////////////
  // Transmit stage.
  ////////////////////////////////////////////////////////////////////////////
  // Between frames the line must rest at the idle level.
  idle_line_high: assert property (@(posedge clk) disable iff (!rst_n) !tx_busy |-> tx_line)
    else $error("tx_line is low while uart_tx is idle.");

  // The done flag belongs to the idle state only.
  done_not_busy: assert property (@(posedge clk) disable iff (!rst_n) !(tx_done && tx_busy))
    else $error("tx_done is high while uart_tx is transmitting.");

  ////////////////////////////////////////////////////////////////////////////
  // Receive stage.
  ////////////////////////////////////////////////////////////////////////////
  rdy_after_stop: assert property (@(posedge clk) disable iff (!rst_n)
                                   $rose(rdy) |-> $past(stop_sample))
    else $error("rdy rose without a stop sample.");  // Only a finished frame may set rdy.

endmodule

//--- hdl/uart_link.sv
/*
  Top level of the serial link.
  Holds the transmit stage and the receive stage side by side.
  The serial output and input are separate ports for loopback or direct drive.
*/
`timescale 1ns/1ps

module uart_link (
  input  logic                        clk,        // System clock.
  input  logic                        rst_n,      // Asynchronous reset, active low.
  input  logic                        trmt,       // Start a transmit frame.
  input  logic [uart_pkg::data_w-1:0] tx_data,    // Byte to send.
  output logic                        tx_done,    // Transmit frame finished.
  output logic                        tx_line,    // Serial output of the transmitter.
  input  logic                        rx_line,    // Serial input of the receiver.
  input  logic                        clr_rdy,    // Clear the ready flag.
  output logic [uart_pkg::data_w-1:0] rx_data,    // Byte received.
  output logic                        rdy,        // Received byte is waiting.
  output logic                        frame_err   // Stop bit of the last frame was low.
);

  ////////////////////////////////////////////////////////////////////////////
  // Transmit stage.
  ////////////////////////////////////////////////////////////////////////////
  uart_tx i_uart_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .trmt    (trmt),
    .tx_data (tx_data),
    .tx_done (tx_done),
    .tx_line (tx_line)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Receive stage.
  ////////////////////////////////////////////////////////////////////////////
  uart_rx i_uart_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_line   (rx_line),
    .clr_rdy   (clr_rdy),
    .rx_data   (rx_data),
    .rdy       (rdy),
    .frame_err (frame_err)
  );

endmodule

//--- hdl/uart_rx.sv
/*
  Receive stage of the serial link.
  Synchronizes the serial line, detects a start edge and checks it at mid-bit.
  Samples the data and stop bits at their middles and rebuilds the byte.
  Holds the ready flag and the framing error flag.
*/
`timescale 1ns/1ps

module uart_rx (
  input  logic                        clk,        // System clock.
  input  logic                        rst_n,      // Asynchronous reset, active low.
  input  logic                        rx_line,    // Serial input, asynchronous to clk.
  input  logic                        clr_rdy,    // Pulse to clear rdy once rx_data is taken.
  output logic [uart_pkg::data_w-1:0] rx_data,    // Last byte received.
  output logic                        rdy,        // A new byte waits in rx_data.
  output logic                        frame_err   // The last stop bit read as 0.
);

  ////////////////////////////////////////////////////////////////////////////
  // Local constants and types.
  ////////////////////////////////////////////////////////////////////////////
  // Bit count at which the stop bit is sampled, after all data bits.
  localparam logic [uart_pkg::bit_cnt_w-1:0] stop_idx = uart_pkg::frame_bits - 4'd2;

  typedef enum logic [1:0] {
    idle,       // Waiting for a falling edge on the line.
    start_chk,  // Waiting for the middle of the start bit.
    rcv         // Sampling data bits and the stop bit.
  } state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Internal signals.
  ////////////////////////////////////////////////////////////////////////////
  state_t                          state;        // Current FSM state.
  state_t                          next_state;   // FSM state for the next cycle.
  logic                            rx_ff1;       // First synchronizer stage.
  logic                            rx_sync;      // Second stage, safe to use.
  logic                            rx_prev;      // rx_sync one cycle back.
  logic                            start_edge;   // High for one cycle on a falling line.
  logic [uart_pkg::baud_cnt_w-1:0] baud_cnt;     // Counts down to the next sample point.
  logic                            baud_tick;    // Sample point reached.
  logic [uart_pkg::bit_cnt_w-1:0]  bit_cnt;      // Data bits sampled so far.
  logic [uart_pkg::data_w-1:0]     rx_shft;      // Data bits collected LSB first.
  logic                            load_half;    // Start edge seen, time half a bit.
  logic                            start_ok;     // Start bit still low at mid-bit.
  logic                            data_sample;  // Take one data bit.
  logic                            stop_sample;  // Take the stop bit and finish the frame.

  ////////////////////////////////////////////////////////////////////////////
  // Synchronizer and edge detection.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rx_ff1  <= 1'b1;                                       // Line is assumed idle high.
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_ff1  <= rx_line;
      rx_sync <= rx_ff1;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_prev & ~rx_sync;                    // High to low on the line.

  ////////////////////////////////////////////////////////////////////////////
  // Sample timing.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      baud_cnt <= '0;
    end else if (load_half) begin
      baud_cnt <= uart_pkg::half_baud;                       // Aim at the middle of the start bit.
    end else if (start_ok || data_sample) begin
      baud_cnt <= uart_pkg::baud_div;                        // One full bit to the next middle.
    end else if (state != idle) begin
      baud_cnt <= baud_cnt - 1'b1;
    end
  end

  // Terminal count of one, so a preload of N spans exactly N cycles.
  assign baud_tick = (baud_cnt == 1);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '0;
    end else if (start_ok) begin
      bit_cnt <= '0;                                         // Frame accepted, count from zero.
    end else if (data_sample) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data path.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rx_shft <= '0;
    end else if (data_sample) begin
      rx_shft <= {rx_sync, rx_shft[uart_pkg::data_w-1:1]};  // New bit enters at the top.
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rx_data <= '0;
    end else if (stop_sample) begin
      rx_data <= rx_shft;                                    // Overwrites any unread byte.
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Status flags.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rdy <= 1'b0;
    end else if (stop_sample) begin
      rdy <= 1'b1;                                           // Setting wins over a clear.
    end else if (clr_rdy || start_ok) begin
      rdy <= 1'b0;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      frame_err <= 1'b0;
    end else if (stop_sample) begin
      frame_err <= ~rx_sync;                                 // A low stop bit is a framing error.
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state  = state;
    load_half   = 1'b0;
    start_ok    = 1'b0;
    data_sample = 1'b0;
    stop_sample = 1'b0;

    case (state)
      start_chk: begin
        if (baud_tick) begin
          if (rx_sync) begin
            next_state = idle;                               // Line went back high, a glitch.
          end else begin
            start_ok   = 1'b1;
            next_state = rcv;
          end
        end
      end

      rcv: begin
        if (baud_tick) begin
          if (bit_cnt == stop_idx) begin
            stop_sample = 1'b1;                              // All data bits are in.
            next_state  = idle;
          end else begin
            data_sample = 1'b1;
          end
        end
      end

      default: begin
        if (start_edge) begin
          load_half  = 1'b1;                                 // Possible start bit.
          next_state = start_chk;
        end
      end
    endcase
  end

endmodule

//--- hdl/uart_tx.sv
/*
  Transmit stage of the serial link.
  Serializes one byte into a start bit, eight data bits sent LSB first and a stop bit.
  A two-state FSM, a baud counter and a bit counter time the frame.
  The done flag holds from the end of a frame until the next accepted strobe.
*/
`timescale 1ns/1ps

module uart_tx (
  input  logic                        clk,      // System clock.
  input  logic                        rst_n,    // Asynchronous reset, active low.
  input  logic                        trmt,     // One-cycle strobe that starts a frame.
  input  logic [uart_pkg::data_w-1:0] tx_data,  // Byte taken in the cycle trmt is honored.
  output logic                        tx_done,  // High from the end of a frame to the next trmt.
  output logic                        tx_line   // Serial output, high while idle.
);

  ////////////////////////////////////////////////////////////////////////////
  // Local constants and types.
  ////////////////////////////////////////////////////////////////////////////
  // Last count of a bit period, so each bit holds exactly baud_div cycles.
  localparam logic [uart_pkg::baud_cnt_w-1:0] baud_last = uart_pkg::baud_div - 1'b1;

  typedef enum logic {
    idle,  // Line held high, waiting for trmt.
    trm    // Frame in progress.
  } state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Internal signals.
  ////////////////////////////////////////////////////////////////////////////
  state_t                          state;         // Current FSM state.
  state_t                          next_state;    // FSM state for the next cycle.
  logic [uart_pkg::data_w:0]       tx_shft;       // Data byte with the start bit below it.
  logic [uart_pkg::baud_cnt_w-1:0] baud_cnt;      // Clocks spent on the current bit.
  logic [uart_pkg::bit_cnt_w-1:0]  bit_cnt;       // Bits already sent in this frame.
  logic                            init;          // Loads the shift register and starts a frame.
  logic                            shift;         // Moves the next bit onto the line.
  logic                            transmitting;  // Baud counter runs while this is high.
  logic                            set_done;      // Frame has ended, set tx_done.

  ////////////////////////////////////////////////////////////////////////////
  // Shift register and line output.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      tx_shft <= '1;                                         // All ones keeps the line idle.
    end else if (init) begin
      tx_shft <= {tx_data, 1'b0};                            // Start bit goes out first.
    end else if (shift) begin
      tx_shft <= {1'b1, tx_shft[uart_pkg::data_w:1]};       // Ones fill in and form the stop bit.
    end
  end

  assign tx_line = tx_shft[0];                               // The LSB is always on the line.

  ////////////////////////////////////////////////////////////////////////////
  // Bit timing.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      baud_cnt <= '0;
    end else if (init || shift) begin
      baud_cnt <= '0;                                        // A new bit period begins.
    end else if (transmitting) begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  assign shift = transmitting && (baud_cnt == baud_last);   // End of the current bit.

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt <= '0;
    end else if (init) begin
      bit_cnt <= '0;                                         // Fresh count for each frame.
    end else if (shift) begin
      bit_cnt <= bit_cnt + 1'b1;                             // One more bit has left the line.
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Done flag.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      tx_done <= 1'b0;
    end else if (init) begin
      tx_done <= 1'b0;                                       // Falls on the edge that takes trmt.
    end else if (set_done) begin
      tx_done <= 1'b1;                                       // Stop bit has been held in full.
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state   = state;                                    // Stay put unless told otherwise.
    init         = 1'b0;
    transmitting = 1'b0;
    set_done     = 1'b0;

    case (state)
      trm: begin
        if (bit_cnt == uart_pkg::frame_bits) begin
          set_done   = 1'b1;                                 // All ten bits are out.
          next_state = idle;
        end else begin
          transmitting = 1'b1;                               // Keep timing the current bit.
        end
      end

      default: begin
        if (trmt) begin
          init       = 1'b1;                                 // Strobe is honored only here.
          next_state = trm;
        end
      end
    endcase
  end

endmodule

//--- hdl/uart_pkg.sv
/*
  Shared constants of the serial link.
  Baud divisor, half-bit offset, frame and data widths, and counter widths.
*/

package uart_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Counter and data widths.
  ////////////////////////////////////////////////////////////////////////////
  localparam int baud_cnt_w = 12;  // Wide enough to hold one full bit period.
  localparam int bit_cnt_w  = 4;   // Wide enough to count every bit of a frame.
  localparam int data_w     = 8;   // Data bits carried by one frame.

  ////////////////////////////////////////////////////////////////////////////
  // Bit timing.
  ////////////////////////////////////////////////////////////////////////////
  // 2604 clocks per bit gives 19200 baud from a 50 MHz clock.
  localparam logic [baud_cnt_w-1:0] baud_div = 12'd2604;

  // Offset from a start edge to the middle of the start bit.
  localparam logic [baud_cnt_w-1:0] half_baud = baud_div >> 1;

  ////////////////////////////////////////////////////////////////////////////
  // Frame layout.
  ////////////////////////////////////////////////////////////////////////////
  // Start bit, data_w data bits and one stop bit.
  localparam logic [bit_cnt_w-1:0] frame_bits = 4'd10;

endpackage
